// File: verilog/icache_pkg.sv
package icache_pkg;

    // fetch address layout: tag | index | offset
    localparam int addr_w   = 32;
    localparam int tag_w    = 23;
    localparam int index_w  = 6;
    localparam int offset_w = 3;
    localparam int sets     = 64;

    // payload widths
    localparam int word_w = 32;
    localparam int line_w = 64;
    localparam int cnt_w  = 32;

    // one way of a tag set
    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    // tag ram payload, both ways side by side
    typedef struct packed {
        tag_entry_t way1;
        tag_entry_t way0;
    } tag_set_t;

    // data ram payload
    typedef struct packed {
        logic [line_w-1:0] way1;
        logic [line_w-1:0] way0;
    } data_set_t;

    // register map of the control port
    typedef enum logic [1:0] {
        csr_ctrl     = 2'd0,
        csr_status   = 2'd1,
        csr_hit_cnt  = 2'd2,
        csr_miss_cnt = 2'd3
    } csr_addr_e;

endpackage

// File: verilog/icache_array_if.sv
`timescale 1ns/100ps

interface icache_array_if #(
    parameter type entry_t = logic
);
    import icache_pkg::*;

    logic [index_w-1:0] index;
    logic               ren;
    logic               wen;
    entry_t             wdata;
    // registered read result, held until the next read
    entry_t             rdata;

    modport ctrl (
        output index,
        output ren,
        output wen,
        output wdata,
        input  rdata
    );

    modport ram (
        input  index,
        input  ren,
        input  wen,
        input  wdata,
        output rdata
    );

endinterface

// File: verilog/icache_sram.sv
`timescale 1ns/100ps

module icache_sram #(
    parameter type entry_t = logic
) (
    input logic          clk,
    icache_array_if.ram  port
);
    import icache_pkg::*;

    entry_t mem [sets];

    // synchronous write
    always_ff @(posedge clk) begin
        if (port.wen) begin
            mem[port.index] <= port.wdata;
        end
    end

    // one-cycle read latency, output holds between reads
    // a read together with a write returns the new entry
    always_ff @(posedge clk) begin
        if (port.ren) begin
            if (port.wen) begin
                port.rdata <= port.wdata;
            end else begin
                port.rdata <= mem[port.index];
            end
        end
    end

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid,
    input  logic [icache_pkg::addr_w-1:0] addr,
    output logic                          addr_ok,
    output logic                          data_ok,
    output logic [icache_pkg::word_w-1:0] rdata,
    output logic                          rd_req,
    output logic [icache_pkg::addr_w-1:0] rd_addr,
    input  logic                          ret_valid,
    input  logic [icache_pkg::line_w-1:0] ret_data,
    icache_array_if.ctrl                  tag_port,
    icache_array_if.ctrl                  data_port,
    input  logic                          enable,
    input  logic                          flush_start,
    output logic                          flush_busy,
    output logic                          hit,
    output logic                          miss
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_done,
        st_miss,
        st_refill_wait,
        st_replace,
        st_flush
    } state_e;

    state_e state;
    state_e next_state;

    // control state
    logic               flush_pend;
    logic               victim;
    logic               refilled_q;
    logic [index_w-1:0] flush_cnt;

    // request buffer and payload
    logic [addr_w-1:0]  req_addr;
    logic               bypass_q;
    logic [word_w-1:0]  word_q;
    logic [line_w-1:0]  line_q;

    logic               flush_req;
    logic               accept;
    logic [tag_w-1:0]   req_tag;
    logic [index_w-1:0] req_index;
    logic [index_w-1:0] in_index;
    logic               word_sel;
    tag_set_t           tag_rd;
    tag_set_t           tag_wr;
    data_set_t          data_rd;
    data_set_t          data_wr;
    logic               way0_hit;
    logic               way1_hit;
    logic               cache_hit;
    logic               fill_way;
    logic [line_w-1:0]  hit_line;

    function automatic logic [word_w-1:0] pick_word(
        input logic [line_w-1:0] line,
        input logic              sel
    );
        pick_word = sel ? line[line_w-1 -: word_w] : line[word_w-1:0];
    endfunction

    assign req_tag   = req_addr[addr_w-1 -: tag_w];
    assign req_index = req_addr[offset_w +: index_w];
    assign word_sel  = req_addr[offset_w-1];
    assign in_index  = addr[offset_w +: index_w];

    // a flush waits for the fetch in flight, and blocks new ones
    assign flush_req = flush_start | flush_pend;
    assign addr_ok   = (state == st_idle || state == st_done) && !flush_req;
    assign accept    = valid && addr_ok;

    // tag compare
    assign tag_rd    = tag_port.rdata;
    assign data_rd   = data_port.rdata;
    assign way0_hit  = tag_rd.way0.valid && (tag_rd.way0.tag == req_tag);
    assign way1_hit  = tag_rd.way1.valid && (tag_rd.way1.tag == req_tag);
    assign cache_hit = way0_hit | way1_hit;
    assign hit_line  = way1_hit ? data_rd.way1 : data_rd.way0;

    // empty way first, otherwise the toggling victim
    assign fill_way = !tag_rd.way0.valid ? 1'b0 :
                      !tag_rd.way1.valid ? 1'b1 : victim;

    always_comb begin
        case (state)
            st_idle, st_done: begin
                if (flush_req) begin
                    next_state = st_flush;
                end else if (accept) begin
                    next_state = enable ? st_lookup : st_miss;
                end else begin
                    next_state = st_idle;
                end
            end
            st_lookup:      next_state = cache_hit ? st_done : st_miss;
            st_miss:        next_state = st_refill_wait;
            st_refill_wait: begin
                if (ret_valid) begin
                    next_state = bypass_q ? st_done : st_replace;
                end else begin
                    next_state = st_refill_wait;
                end
            end
            // re-read happens in the same cycle as the write
            st_replace:     next_state = st_lookup;
            st_flush: begin
                if (flush_cnt == index_w'(sets - 1)) begin
                    next_state = st_idle;
                end else begin
                    next_state = st_flush;
                end
            end
            default:        next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            flush_pend <= 1'b0;
            victim     <= 1'b0;
            refilled_q <= 1'b0;
            flush_cnt  <= '0;
        end else begin
            state      <= next_state;
            flush_pend <= flush_req && !(next_state == st_flush && state != st_flush);
            if (state == st_flush) begin
                flush_cnt <= flush_cnt + 1'b1;
            end else begin
                flush_cnt <= '0;
            end
            if (state == st_replace) begin
                victim <= ~victim;
            end
            // the lookup right after a refill is not a real hit
            if (accept) begin
                refilled_q <= 1'b0;
            end else if (state == st_replace) begin
                refilled_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= addr;
            bypass_q <= !enable;
        end
        if (state == st_lookup) begin
            word_q <= pick_word(hit_line, word_sel);
        end
        if (state == st_refill_wait && ret_valid) begin
            line_q <= ret_data;
            if (bypass_q) begin
                word_q <= pick_word(ret_data, word_sel);
            end
        end
    end

    // refill keeps the other way untouched
    always_comb begin
        tag_wr  = tag_rd;
        data_wr = data_rd;
        if (state == st_flush) begin
            tag_wr = '0;
        end else if (fill_way) begin
            tag_wr.way1.valid = 1'b1;
            tag_wr.way1.tag   = req_tag;
            data_wr.way1      = line_q;
        end else begin
            tag_wr.way0.valid = 1'b1;
            tag_wr.way0.tag   = req_tag;
            data_wr.way0      = line_q;
        end
    end

    always_comb begin
        if (state == st_flush) begin
            tag_port.index = flush_cnt;
        end else if (state == st_replace) begin
            tag_port.index = req_index;
        end else begin
            tag_port.index = in_index;
        end
        data_port.index = (state == st_replace) ? req_index : in_index;
        tag_port.ren    = (accept && enable) || state == st_replace;
        data_port.ren   = (accept && enable) || state == st_replace;
        tag_port.wen    = state == st_replace || state == st_flush;
        data_port.wen   = state == st_replace;
        tag_port.wdata  = tag_wr;
        data_port.wdata = data_wr;
    end

    assign data_ok    = state == st_done;
    assign rdata      = word_q;
    assign rd_req     = state == st_miss;
    assign rd_addr    = {req_addr[addr_w-1:offset_w], offset_w'(0)};
    assign flush_busy = state == st_flush;
    assign hit        = state == st_lookup && cache_hit && !refilled_q;
    assign miss       = state == st_lookup && !cache_hit;

endmodule

// File: verilog/icache_csr.sv
`timescale 1ns/100ps

module icache_csr (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cfg_wr,
    input  icache_pkg::csr_addr_e cfg_addr,
    input  logic [31:0]           cfg_wdata,
    output logic [31:0]           cfg_rdata,
    output logic                  enable,
    output logic                  flush_start,
    input  logic                  flush_busy,
    input  logic                  hit,
    input  logic                  miss
);
    import icache_pkg::*;

    logic             ctrl_wr;
    logic             clear_cnt;
    logic [cnt_w-1:0] hit_cnt;
    logic [cnt_w-1:0] miss_cnt;

    // saturating event counter step
    function automatic logic [cnt_w-1:0] bump(
        input logic [cnt_w-1:0] cnt,
        input logic             ev,
        input logic             clr
    );
        if (clr) begin
            bump = '0;
        end else if (ev && cnt != '1) begin
            bump = cnt + 1'b1;
        end else begin
            bump = cnt;
        end
    endfunction

    assign ctrl_wr   = cfg_wr && cfg_addr == csr_ctrl;
    // flush command also restarts the statistics
    assign clear_cnt = ctrl_wr && cfg_wdata[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            enable      <= 1'b1;
            flush_start <= 1'b0;
            hit_cnt     <= '0;
            miss_cnt    <= '0;
        end else begin
            flush_start <= clear_cnt;
            if (ctrl_wr) begin
                enable <= cfg_wdata[0];
            end
            hit_cnt  <= bump(hit_cnt, hit, clear_cnt);
            miss_cnt <= bump(miss_cnt, miss, clear_cnt);
        end
    end

    // busy covers the pulse cycle before the controller starts
    always_comb begin
        case (cfg_addr)
            csr_ctrl:     cfg_rdata = {31'b0, enable};
            csr_status:   cfg_rdata = {31'b0, flush_busy | flush_start};
            csr_hit_cnt:  cfg_rdata = hit_cnt;
            csr_miss_cnt: cfg_rdata = miss_cnt;
            default:      cfg_rdata = '0;
        endcase
    end

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/100ps

module icache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid,
    input  logic [icache_pkg::addr_w-1:0] addr,
    output logic                          addr_ok,
    output logic                          data_ok,
    output logic [icache_pkg::word_w-1:0] rdata,
    output logic                          rd_req,
    output logic [icache_pkg::addr_w-1:0] rd_addr,
    input  logic                          ret_valid,
    input  logic [icache_pkg::line_w-1:0] ret_data,
    input  logic                          cfg_wr,
    input  icache_pkg::csr_addr_e         cfg_addr,
    input  logic [31:0]                   cfg_wdata,
    output logic [31:0]                   cfg_rdata
);
    import icache_pkg::*;

    logic enable;
    logic flush_start;
    logic flush_busy;
    logic hit;
    logic miss;

    icache_array_if #(.entry_t(tag_set_t))  tag_bus ();
    icache_array_if #(.entry_t(data_set_t)) data_bus ();

    icache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .addr        (addr),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data),
        .tag_port    (tag_bus.ctrl),
        .data_port   (data_bus.ctrl),
        .enable      (enable),
        .flush_start (flush_start),
        .flush_busy  (flush_busy),
        .hit         (hit),
        .miss        (miss)
    );

    icache_csr u_csr (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .enable      (enable),
        .flush_start (flush_start),
        .flush_busy  (flush_busy),
        .hit         (hit),
        .miss        (miss)
    );

    icache_sram #(.entry_t(tag_set_t)) u_tag_ram (
        .clk  (clk),
        .port (tag_bus.ram)
    );

    icache_sram #(.entry_t(data_set_t)) u_data_ram (
        .clk  (clk),
        .port (data_bus.ram)
    );

endmodule

// File: verif/icache_props.sv
`timescale 1ns/100ps

module icache_props (
    input logic clk,
    input logic rst,
    input logic valid,
    input logic addr_ok,
    input logic data_ok,
    input logic rd_req,
    input logic ret_valid,
    input logic flush_busy
);
    import icache_pkg::*;

    logic       req_open;
    logic [7:0] busy_len;

    // read in flight between rd_req and ret_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            req_open <= 1'b0;
            busy_len <= '0;
        end else begin
            if (rd_req) begin
                req_open <= 1'b1;
            end else if (ret_valid) begin
                req_open <= 1'b0;
            end
            if (flush_busy) begin
                busy_len <= busy_len + 8'd1;
            end else begin
                busy_len <= '0;
            end
        end
    end

    // no word comes back in the cycle right after an accept
    no_early_data: assert property (@(posedge clk) disable iff (rst)
        (valid && addr_ok) |=> !data_ok)
        else $error("data_ok raised in the cycle after an accept");

    req_pulse: assert property (@(posedge clk) disable iff (rst)
        rd_req |=> !rd_req)
        else $error("rd_req held longer than one cycle");

    one_outstanding: assert property (@(posedge clk) disable iff (rst)
        rd_req |-> !req_open)
        else $error("second rd_req before ret_valid");

    flush_len: assert property (@(posedge clk) disable iff (rst)
        $fell(flush_busy) |-> busy_len == 8'(sets))
        else $error("flush_busy length is not one cycle per set");

endmodule

bind icache_ctrl icache_props u_props (
    .clk        (clk),
    .rst        (rst),
    .valid      (valid),
    .addr_ok    (addr_ok),
    .data_ok    (data_ok),
    .rd_req     (rd_req),
    .ret_valid  (ret_valid),
    .flush_busy (flush_busy)
);

// File: verif/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;
    import icache_pkg::*;

    localparam int reset_cycles = 16;
    // worst fetch is a refill after 6 cycles of memory latency plus margin
    localparam int fetch_worst  = 16;
    localparam int fetch_count  = 20;
    localparam int flush_worst  = 70;
    localparam int flush_count  = 2;
    localparam int timeout_cycles = reset_cycles + fetch_count * fetch_worst +
                                    flush_count * flush_worst + 200;

    logic              clk;
    logic              rst;
    logic              valid;
    logic [addr_w-1:0] addr;
    logic              addr_ok;
    logic              data_ok;
    logic [word_w-1:0] rdata;
    logic              rd_req;
    logic [addr_w-1:0] rd_addr;
    logic              ret_valid;
    logic [line_w-1:0] ret_data;
    logic              cfg_wr;
    csr_addr_e         cfg_addr;
    logic [31:0]       cfg_wdata;
    logic [31:0]       cfg_rdata;

    int                checks;
    int                errors;
    int                fills;
    int                cycles;
    int                exp_hits;
    int                exp_misses;
    logic              cache_on;
    logic [addr_w-1:0] seen [$];

    icache_top UUT (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .addr      (addr),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // memory content is a fixed scramble of the word address
    function automatic logic [word_w-1:0] mem_word(input logic [addr_w-1:0] a);
        logic [addr_w-1:0] w;
        w = {a[addr_w-1:2], 2'b00};
        mem_word = (w * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    // next level memory answers one read at a time after 1 to 6 cycles
    initial begin : mem_model
        logic [addr_w-1:0] line_a;
        int unsigned       delay;
        void'($urandom(32'hc77d5635));
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            tick();
            if (rd_req) begin
                line_a = rd_addr;
                delay  = 1 + ($urandom % 6);
                repeat (delay) tick();
                ret_data  = {mem_word(line_a + 32'd4), mem_word(line_a)};
                ret_valid = 1'b1;
                tick();
                ret_valid = 1'b0;
            end
        end
    end

    task automatic check_word(input string name, input logic [word_w-1:0] got,
                              input logic [word_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [cnt_w-1:0] got,
                               input logic [cnt_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic write_cfg(input csr_addr_e a, input logic [31:0] d);
        tick();
        cfg_wr    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        if (a == csr_ctrl) begin
            cache_on = d[0];
        end
        tick();
        cfg_wr    = 1'b0;
        cfg_wdata = '0;
    endtask

    task automatic read_cfg(input csr_addr_e a, output logic [31:0] v);
        cfg_addr = a;
        #1;
        v = cfg_rdata;
    endtask

    task automatic expect_stats(input logic [cnt_w-1:0] exp_hit,
                                input logic [cnt_w-1:0] exp_miss);
        logic [31:0] v;
        read_cfg(csr_hit_cnt, v);
        check_count("hit_cnt", v, exp_hit);
        read_cfg(csr_miss_cnt, v);
        check_count("miss_cnt", v, exp_miss);
    endtask

    // flush with the cache left on clears the counters too
    task automatic run_flush();
        logic [31:0] st;
        int          busy;
        busy = 0;
        write_cfg(csr_ctrl, 32'h3);
        exp_hits   = 0;
        exp_misses = 0;
        read_cfg(csr_status, st);
        check_level("status busy", st[0], 1'b1);
        while (st[0]) begin
            check_level("addr_ok", addr_ok, 1'b0);
            busy++;
            tick();
            read_cfg(csr_status, st);
        end
        // command cycle plus one per set
        check_count("flush busy cycles", busy, 65);
    endtask

    task automatic fetch(input logic [addr_w-1:0] a, output logic [word_w-1:0] word,
                         output int lat, output int reqs, output logic [addr_w-1:0] req_a);
        reqs  = 0;
        req_a = '0;
        tick();
        while (!addr_ok) tick();
        valid = 1'b1;
        addr  = a;
        tick();
        valid = 1'b0;
        lat   = 1;
        while (!data_ok) begin
            if (rd_req) begin
                reqs++;
                req_a = rd_addr;
            end
            tick();
            lat++;
        end
        word = rdata;
        if (reqs > 0 && cache_on) begin
            fills++;
        end
    endtask

    task automatic fetch_check(input logic [addr_w-1:0] a, input logic expect_miss,
                               output int reqs);
        logic [word_w-1:0] word;
        logic [addr_w-1:0] req_a;
        int                lat;
        fetch(a, word, lat, reqs, req_a);
        // only cached fetches are counted
        if (cache_on) begin
            if (expect_miss) begin
                exp_misses++;
            end else begin
                exp_hits++;
            end
        end
        check_word("rdata", word, mem_word(a));
        check_count("rd_req pulses", reqs, expect_miss ? 1 : 0);
        if (expect_miss) begin
            check_word("rd_addr", req_a, {a[addr_w-1:3], 3'b000});
        end else begin
            check_count("hit latency", lat, 2);
        end
    endtask

    task automatic cold_miss();
        int reqs;
        run_flush();
        fetch_check(32'h0000_1a40, 1'b1, reqs);
        expect_stats(0, 1);
        seen.push_back(32'h0000_1a40);
    endtask

    task automatic repeat_hit();
        int reqs;
        fetch_check(32'h0000_1a40, 1'b0, reqs);
        expect_stats(1, 1);
        // other word of the same line
        fetch_check(32'h0000_1a44, 1'b0, reqs);
        expect_stats(2, 1);
    endtask

    task automatic set_conflict();
        logic [addr_w-1:0] first;
        logic [addr_w-1:0] second;
        logic [addr_w-1:0] third;
        int                reqs;
        int                total;
        first  = 32'h0000_4328;
        second = 32'h0001_4328;
        third  = 32'h0002_4328;
        // even fill count so the toggle points the third tag at the oldest line
        if (fills % 2 != 0) begin
            fetch_check(32'h0000_7f00, 1'b1, reqs);
            seen.push_back(32'h0000_7f00);
        end
        fetch_check(first, 1'b1, reqs);
        fetch_check(second, 1'b1, reqs);
        fetch_check(first, 1'b0, reqs);
        fetch_check(second, 1'b0, reqs);
        fetch_check(third, 1'b1, reqs);
        // survivor first so its refetch cannot evict anything
        total = 0;
        fetch_check(second, 1'b0, reqs);
        total += reqs;
        fetch_check(first, 1'b1, reqs);
        total += reqs;
        check_count("rd_req over both refetches", total, 1);
        seen.push_back(first);
        seen.push_back(second);
        seen.push_back(third);
    endtask

    task automatic flush_refetch();
        int reqs;
        run_flush();
        expect_stats(0, 0);
        foreach (seen[i]) begin
            fetch_check(seen[i], 1'b1, reqs);
        end
        expect_stats(0, seen.size());
    endtask

    task automatic bypass_mode();
        logic [31:0]       v;
        logic [addr_w-1:0] fresh;
        int                reqs;
        fresh = 32'h0003_9a0c;
        write_cfg(csr_ctrl, 32'h0);
        read_cfg(csr_ctrl, v);
        check_level("enable", v[0], 1'b0);
        fetch_check(fresh, 1'b1, reqs);
        // resident line still goes to memory
        fetch_check(seen[0], 1'b1, reqs);
        fetch_check(fresh, 1'b1, reqs);
        expect_stats(exp_hits, exp_misses);
        write_cfg(csr_ctrl, 32'h1);
        fetch_check(fresh, 1'b1, reqs);
        expect_stats(exp_hits, exp_misses);
    endtask

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        valid      = 1'b0;
        addr       = '0;
        cfg_wr     = 1'b0;
        cfg_addr   = csr_ctrl;
        cfg_wdata  = '0;
        checks     = 0;
        errors     = 0;
        fills      = 0;
        exp_hits   = 0;
        exp_misses = 0;
        cache_on   = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();
        cold_miss();
        repeat_hit();
        set_conflict();
        flush_refetch();
        bypass_mode();
        tick();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
verilog/icache_pkg.sv
verilog/icache_array_if.sv
verilog/icache_sram.sv
verilog/icache_ctrl.sv
verilog/icache_csr.sv
verilog/icache_top.sv
verif/icache_props.sv
verif/icache_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = icache_tb
FILELIST = list.f
LOG      = sim.log
FAIL_MSG = STATUS: FAIL

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
